// ==== logic/weiDist_macros.svh ====
/*
 * Sizes and widths of the weight distributor.
 * Included by the package and by every RTL file that sizes arrays or loops.
 */
`ifndef WEI_DIST_MACROS_SVH
`define WEI_DIST_MACROS_SVH

// ==================================================================
// Array geometry
// ==================================================================
`define WEI_DATA_WIDTH      8
`define WEI_BLOCK_DEPTH     4
`define WEI_KERNEL_SIZE     9
`define WEI_PORT_BYTES      4

// Buffer address widths
`define WEI_FLAG_ADDR_WIDTH 8
`define WEI_ADDR_WIDTH      10

// Max total (36) plus one read, rounded up
`define WEI_QUEUE_BYTES     40

// Derived widths
`define WEI_FLAG_WIDTH      (`WEI_KERNEL_SIZE * `WEI_BLOCK_DEPTH)
`define WEI_PORT_WIDTH      (`WEI_DATA_WIDTH * `WEI_PORT_BYTES)
`define WEI_BLOCK_WIDTH     (`WEI_DATA_WIDTH * `WEI_FLAG_WIDTH)
`define WEI_COUNT_WIDTH     3
`define WEI_OFFSET_WIDTH    6

`endif

// ==== logic/weiPkg.sv ====
/*
 * Shared types of the weight distributor.
 * Referenced with scoped names from the RTL and the testbench.
 */
`include "weiDist_macros.svh"

package weiPkg;

    // ==================================================================
    // Data widths
    // ==================================================================
    // One weight
    typedef logic [`WEI_DATA_WIDTH-1:0]      weiByteT;
    // One weight buffer read, byte 0 in the low lane
    typedef logic [`WEI_PORT_WIDTH-1:0]      portWordT;
    // Bit index is position * block depth + channel
    typedef logic [`WEI_FLAG_WIDTH-1:0]      flagWordT;
    // Nonzero count of one kernel position, 0..4
    typedef logic [`WEI_COUNT_WIDTH-1:0]     countT;
    // Byte offset or total, 0..36 (also used for queue fill)
    typedef logic [`WEI_OFFSET_WIDTH-1:0]    offsetT;
    // All slots, slot i in bytes 4i..4i+3
    typedef logic [`WEI_BLOCK_WIDTH-1:0]     weiBlockT;

    // Buffer addresses
    typedef logic [`WEI_FLAG_ADDR_WIDTH-1:0] flagAddrT;
    typedef logic [`WEI_ADDR_WIDTH-1:0]      weiAddrT;

    // ==================================================================
    // Gather FSM
    // ==================================================================
    typedef enum logic [1:0] {
        gsIdle,
        gsWaitFlag,
        gsRead,
        gsDrain
    } gatherStateT;

endpackage

// ==== logic/flagInfoIf.sv ====
/*
 * One decoded flag word, from the flag stage to the gather and align stages.
 * Values hold until the next flagValid pulse.
 */
`timescale 1ns/1ps
`include "weiDist_macros.svh"

interface flagInfoIf;

    // One-cycle pulse, new word below
    logic flagValid;
    weiPkg::flagWordT flags;
    // Per-position nonzero counts
    weiPkg::countT [`WEI_KERNEL_SIZE-1:0] counts;
    // Exclusive prefix sums of counts
    weiPkg::offsetT [`WEI_KERNEL_SIZE-1:0] offsets;
    // Bytes needed by the whole word
    weiPkg::offsetT total;

    // Flag stage drives everything
    modport src (output flagValid, flags, counts, offsets, total);

    // Gather only needs the byte budget
    modport gather (input flagValid, total);

    // Align slices the window per position
    modport align (input flags, counts, offsets);

endinterface

// ==== logic/flagFetch.sv ====
/*
 * Input side. Reads one flag word per accepted fetch, counts the nonzero
 * weights per kernel position and publishes counts, offsets and total.
 */
`timescale 1ns/1ps
`include "weiDist_macros.svh"

module flagFetch (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetchAccept,
    input  logic             frameDone,
    output logic             flagRdEn,
    output weiPkg::flagAddrT flagRdAddr,
    input  weiPkg::flagWordT flagRdData,
    flagInfoIf.src           info
);

    localparam int KernelSize = `WEI_KERNEL_SIZE;
    localparam int BlockDepth = `WEI_BLOCK_DEPTH;

    // Read issued last cycle, data on the bus now
    logic rdPending;

    weiPkg::countT  [KernelSize-1:0] cntNext;
    weiPkg::offsetT [KernelSize-1:0] offNext;
    weiPkg::offsetT                  totNext;

    // ==================================================================
    // Flag buffer addressing
    // ==================================================================
    // Same cycle as the accepted fetch
    assign flagRdEn = fetchAccept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flagRdAddr <= '0;
        end else if (frameDone) begin
            flagRdAddr <= '0;
        end else if (flagRdEn) begin
            flagRdAddr <= flagRdAddr + 1'b1;
        end
    end

    // Two-stage valid, pulse lands two cycles after fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdPending      <= 1'b0;
            info.flagValid <= 1'b0;
        end else if (frameDone) begin
            rdPending      <= 1'b0;
            info.flagValid <= 1'b0;
        end else begin
            rdPending      <= flagRdEn;
            info.flagValid <= rdPending;
        end
    end

    // ==================================================================
    // Popcount and prefix offsets on the returned word
    // ==================================================================
    always_comb begin
        weiPkg::offsetT acc;
        acc = '0;
        for (int p = 0; p < KernelSize; p++) begin
            cntNext[p] = '0;
            for (int c = 0; c < BlockDepth; c++) begin
                cntNext[p] = cntNext[p] + weiPkg::countT'(flagRdData[p*BlockDepth + c]);
            end
            // Exclusive, position 0 starts at byte 0
            offNext[p] = acc;
            acc        = acc + weiPkg::offsetT'(cntNext[p]);
        end
        totNext = acc;
    end

    // Payload registers, captured with the valid pulse
    always_ff @(posedge clk) begin
        if (rdPending) begin
            info.flags   <= flagRdData;
            info.counts  <= cntNext;
            info.offsets <= offNext;
            info.total   <= totNext;
        end
    end

endmodule

// ==== logic/weiGather.sv ====
/*
 * Processing part. Accepts fetches, reads packed weight words until the
 * flag word's total is queued, then presents the oldest bytes as a window.
 * Leftover bytes stay queued and open the next fetch.
 */
`timescale 1ns/1ps
`include "weiDist_macros.svh"

module weiGather (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch,
    input  logic             frameDone,
    output logic             fetchAccept,
    output logic             weiRdEn,
    output weiPkg::weiAddrT  weiRdAddr,
    input  weiPkg::portWordT weiRdData,
    flagInfoIf.gather        info,
    output logic             windowValid,
    output weiPkg::weiBlockT window
);

    localparam int QueueBytes  = `WEI_QUEUE_BYTES;
    localparam int PortBytes   = `WEI_PORT_BYTES;
    localparam int DataWidth   = `WEI_DATA_WIDTH;
    localparam int WindowBytes = `WEI_FLAG_WIDTH;

    weiPkg::gatherStateT state;
    weiPkg::gatherStateT stateNext;

    // Byte queue, entry 0 is the oldest
    weiPkg::weiByteT queue [QueueBytes];
    weiPkg::offsetT  fill;

    // At most one word in flight, buffer latency is one cycle
    logic           rdInFlight;
    weiPkg::offsetT flightBytes;
    logic           gathering;

    // ==================================================================
    // Fetch acceptance and read issue
    // ==================================================================
    assign fetchAccept = fetch && !frameDone && (state == weiPkg::gsIdle);

    assign flightBytes = rdInFlight ? weiPkg::offsetT'(PortBytes) : '0;
    assign gathering   = (state == weiPkg::gsRead) || (state == weiPkg::gsDrain);

    // Keep reading while queued plus in flight falls short of total
    assign weiRdEn = (state == weiPkg::gsRead) && !frameDone
                     && ((fill + flightBytes) < info.total);

    // Nothing in flight and enough bytes queued
    assign windowValid = gathering && !rdInFlight && (fill >= info.total);

    // FSM next state
    always_comb begin
        stateNext = state;
        case (state)
            weiPkg::gsIdle: begin
                if (fetchAccept) stateNext = weiPkg::gsWaitFlag;
            end
            weiPkg::gsWaitFlag: begin
                if (info.flagValid) stateNext = weiPkg::gsRead;
            end
            weiPkg::gsRead: begin
                // Zero total or enough leftover finishes here
                if (windowValid) stateNext = weiPkg::gsIdle;
                else if (!weiRdEn) stateNext = weiPkg::gsDrain;
            end
            weiPkg::gsDrain: begin
                if (windowValid) stateNext = weiPkg::gsIdle;
            end
            default: stateNext = weiPkg::gsIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= weiPkg::gsIdle;
            rdInFlight <= 1'b0;
            weiRdAddr  <= '0;
            fill       <= '0;
        end else if (frameDone) begin
            // Emptying fill drops the leftover bytes
            state      <= weiPkg::gsIdle;
            rdInFlight <= 1'b0;
            weiRdAddr  <= '0;
            fill       <= '0;
        end else begin
            state      <= stateNext;
            rdInFlight <= weiRdEn;
            if (weiRdEn) weiRdAddr <= weiRdAddr + 1'b1;
            // Append and pop never coincide, pop needs no read in flight
            if (rdInFlight) begin
                fill <= fill + weiPkg::offsetT'(PortBytes);
            end else if (windowValid) begin
                fill <= fill - info.total;
            end
        end
    end

    // ==================================================================
    // Byte queue
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rdInFlight) begin
            // Returned word lands behind the queued bytes
            for (int k = 0; k < PortBytes; k++) begin
                if (int'(fill) + k < QueueBytes) begin
                    queue[int'(fill) + k] <= weiRdData[k*DataWidth +: DataWidth];
                end
            end
        end else if (windowValid) begin
            // Pop total bytes from the front
            for (int i = 0; i < QueueBytes; i++) begin
                if (i + int'(info.total) < QueueBytes) begin
                    queue[i] <= queue[i + int'(info.total)];
                end
            end
        end
    end

    // Oldest bytes out as the window
    always_comb begin
        for (int i = 0; i < WindowBytes; i++) begin
            window[i*DataWidth +: DataWidth] = queue[i];
        end
    end

endmodule

// ==== logic/weiAlign.sv ====
/*
 * Output side. Slices the gathered window into one slot per kernel
 * position, zero fills unused bytes and holds the result with its flags.
 */
`timescale 1ns/1ps
`include "weiDist_macros.svh"

module weiAlign (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetchAccept,
    input  logic             frameDone,
    input  logic             windowValid,
    input  weiPkg::weiBlockT window,
    flagInfoIf.align         info,
    output weiPkg::weiBlockT weiOut,
    output weiPkg::flagWordT weiFlags,
    output logic             weiRdy
);

    localparam int DataWidth   = `WEI_DATA_WIDTH;
    localparam int BlockDepth  = `WEI_BLOCK_DEPTH;
    localparam int KernelSize  = `WEI_KERNEL_SIZE;
    localparam int WindowBytes = `WEI_FLAG_WIDTH;

    weiPkg::weiBlockT slotsNext;

    // ==================================================================
    // Slot build
    // ==================================================================
    always_comb begin
        int src;
        src       = 0;
        slotsNext = '0;
        for (int p = 0; p < KernelSize; p++) begin
            for (int c = 0; c < BlockDepth; c++) begin
                src = int'(info.offsets[p]) + c;
                // Low bytes of the slot get the position's weights
                if ((c < int'(info.counts[p])) && (src < WindowBytes)) begin
                    slotsNext[(p*BlockDepth + c)*DataWidth +: DataWidth] =
                        window[src*DataWidth +: DataWidth];
                end
            end
        end
    end

    // Result and flags move together
    always_ff @(posedge clk) begin
        if (windowValid) begin
            weiOut   <= slotsNext;
            weiFlags <= info.flags;
        end
    end

    // Ready level, up with the new slots, down after a fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiRdy <= 1'b0;
        end else if (frameDone || fetchAccept) begin
            weiRdy <= 1'b0;
        end else if (windowValid) begin
            weiRdy <= 1'b1;
        end
    end

endmodule

// ==== logic/weiDistTop.sv ====
/*
 * Weight distributor top level. Connects the flag stage, the gather
 * stage and the align stage to the buffer and controller ports.
 */
`timescale 1ns/1ps

module weiDistTop (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch,
    input  logic             frameDone,
    output logic             flagRdEn,
    output weiPkg::flagAddrT flagRdAddr,
    input  weiPkg::flagWordT flagRdData,
    output logic             weiRdEn,
    output weiPkg::weiAddrT  weiRdAddr,
    input  weiPkg::portWordT weiRdData,
    output logic             weiRdy,
    output weiPkg::weiBlockT weiOut,
    output weiPkg::flagWordT weiFlags
);

    // Stage handoff
    logic             fetchAccept;
    logic             windowValid;
    weiPkg::weiBlockT window;

    // Decoded flag word
    flagInfoIf infoBus ();

    // ==================================================================
    // Stages
    // ==================================================================
    flagFetch uFetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetchAccept (fetchAccept),
        .frameDone   (frameDone),
        .flagRdEn    (flagRdEn),
        .flagRdAddr  (flagRdAddr),
        .flagRdData  (flagRdData),
        .info        (infoBus.src)
    );

    weiGather uGather (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch       (fetch),
        .frameDone   (frameDone),
        .fetchAccept (fetchAccept),
        .weiRdEn     (weiRdEn),
        .weiRdAddr   (weiRdAddr),
        .weiRdData   (weiRdData),
        .info        (infoBus.gather),
        .windowValid (windowValid),
        .window      (window)
    );

    weiAlign uAlign (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetchAccept (fetchAccept),
        .frameDone   (frameDone),
        .windowValid (windowValid),
        .window      (window),
        .info        (infoBus.align),
        .weiOut      (weiOut),
        .weiFlags    (weiFlags),
        .weiRdy      (weiRdy)
    );

endmodule

// ==== testbench/tbClock.sv ====
/*
 * Testbench clock and reset source.
 * 40 ns clock, active-low reset released after ResetCycles rising edges.
 */
`timescale 1ns/1ps

module tbClock #(
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic rst_n
);

    // Half of the 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held low, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== testbench/weiDist_asserts.sv ====
/*
 * Protocol assertions for the weight distributor.
 * Bound into weiDistTop, watches the gather FSM and the ready level.
 */
`timescale 1ns/1ps

module weiDistAsserts (
    input logic                clk,
    input logic                rst_n,
    input logic                weiRdEn,
    input logic                weiRdy,
    input logic                fetchAccept,
    input logic                windowValid,
    input weiPkg::gatherStateT gatherState
);

    // ==================================================================
    // Gather stage
    // ==================================================================
    // Weight reads only while the FSM gathers
    rdEnOnlyInRead: assert property (
        @(posedge clk) disable iff (!rst_n)
        weiRdEn |-> (gatherState == weiPkg::gsRead)
    ) else $error("weiRdEn high outside gsRead");

    // Word issued last cycle is still on the buffer bus
    noWindowDuringRead: assert property (
        @(posedge clk) disable iff (!rst_n)
        windowValid |-> !$past(weiRdEn)
    ) else $error("windowValid fired with a weight read in flight");

    // ==================================================================
    // Output side
    // ==================================================================
    rdyDropsAfterFetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetchAccept |=> !weiRdy
    ) else $error("weiRdy still high after an accepted fetch");

endmodule

bind weiDistTop weiDistAsserts uAsserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .weiRdEn     (weiRdEn),
    .weiRdy      (weiRdy),
    .fetchAccept (fetchAccept),
    .windowValid (windowValid),
    .gatherState (uGather.state)
);

// ==== testbench/weiDistTb.sv ====
/*
 * Testbench for the weight distributor. Models both buffers, fills them from
 * an LFSR, runs two frames of fetches and checks every slot against a model.
 */
`timescale 1ns/1ps
`include "weiDist_macros.svh"

module weiDistTb;

    localparam int DataWidth     = `WEI_DATA_WIDTH;
    localparam int BlockDepth    = `WEI_BLOCK_DEPTH;
    localparam int KernelSize    = `WEI_KERNEL_SIZE;
    localparam int PortBytes     = `WEI_PORT_BYTES;
    localparam int FlagDepth     = 1 << `WEI_FLAG_ADDR_WIDTH;
    localparam int WeiDepth      = 1 << `WEI_ADDR_WIDTH;
    localparam int FetchesA      = 60;
    localparam int FetchesB      = 24;
    localparam int ResetCycles   = 16;
    // Idle gap, accept, flag read, nine word reads, window, ready
    localparam int WorstLatency  = 24;
    localparam int TimeoutCycles = ResetCycles + (FetchesA + FetchesB) * WorstLatency + 200;

    logic             clk;
    logic             rst_n;
    logic             fetch      = 1'b0;
    logic             frameDone  = 1'b0;
    logic             flagRdEn;
    weiPkg::flagAddrT flagRdAddr;
    weiPkg::flagWordT flagRdData = '0;
    logic             weiRdEn;
    weiPkg::weiAddrT  weiRdAddr;
    weiPkg::portWordT weiRdData  = '0;
    logic             weiRdy;
    weiPkg::weiBlockT weiOut;
    weiPkg::flagWordT weiFlags;

    weiPkg::flagWordT flagMem [FlagDepth];
    weiPkg::portWordT weiMem [WeiDepth];

    logic [31:0] lfsrState   = 32'h99cc;
    int          streamPtr   = 0;
    int          flagIdx     = 0;
    int          expFlagAddr = 0;
    int          wordsRead   = 0;
    int          errorCount  = 0;
    int          cycleCount  = 0;

    tbClock #(.ResetCycles(ResetCycles)) uClock (.clk(clk), .rst_n(rst_n));

    weiDistTop UUT (
        .clk(clk), .rst_n(rst_n), .fetch(fetch), .frameDone(frameDone),
        .flagRdEn(flagRdEn), .flagRdAddr(flagRdAddr), .flagRdData(flagRdData),
        .weiRdEn(weiRdEn), .weiRdAddr(weiRdAddr), .weiRdData(weiRdData),
        .weiRdy(weiRdy), .weiOut(weiOut), .weiFlags(weiFlags)
    );

    // ==================================================================
    // Buffer models, one cycle read latency
    // ==================================================================
    always @(posedge clk) begin
        if (flagRdEn) flagRdData <= flagMem[flagRdAddr];
        if (weiRdEn) weiRdData <= weiMem[weiRdAddr];
    end

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits      = {bits[30:0], lfsrState[0]};
        end
    endtask

    task automatic compareValue(input string name, input weiPkg::weiBlockT got,
                                input weiPkg::weiBlockT expected);
        if (got !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("Test failures found");
            $fatal(1, "Run stopped at the first mismatch");
        end
    endtask

    task automatic fillMemories();
        logic [31:0]      level;
        logic [31:0]      r;
        weiPkg::flagWordT fw;
        for (int w = 0; w < FlagDepth; w++) begin
            // Density level per word, level 0 leaves it empty
            takeBits(2, level);
            fw = '0;
            for (int b = 0; b < KernelSize * BlockDepth; b++) begin
                if (level[1:0] == 2'd1) begin
                    takeBits(3, r);
                    fw[b] = (r[2:0] == 3'd0);
                end else if (level[1:0] == 2'd2) begin
                    takeBits(1, r);
                    fw[b] = r[0];
                end else if (level[1:0] == 2'd3) begin
                    takeBits(3, r);
                    fw[b] = (r[2:0] != 3'd0);
                end
            end
            flagMem[w] = fw;
        end
        // Empty word early in each frame
        flagMem[1] = '0;
        for (int a = 0; a < WeiDepth; a++) begin
            takeBits(32, r);
            weiMem[a] = r;
        end
    endtask

    // Byte idx of the packed weight stream, byte 0 in the low lane
    function automatic weiPkg::weiByteT streamByte(input int idx);
        return weiMem[idx / PortBytes][(idx % PortBytes) * DataWidth +: DataWidth];
    endfunction

    // Slot p gets count(p) stream bytes in its low bytes, zeros above
    task automatic buildExpected(input weiPkg::flagWordT fw, output weiPkg::weiBlockT expBlock);
        int cnt;
        expBlock = '0;
        for (int p = 0; p < KernelSize; p++) begin
            cnt = 0;
            for (int c = 0; c < BlockDepth; c++) cnt += int'(fw[p * BlockDepth + c]);
            for (int c = 0; c < cnt; c++) begin
                expBlock[(p * BlockDepth + c) * DataWidth +: DataWidth] = streamByte(streamPtr);
                streamPtr++;
            end
        end
    endtask

    task automatic checkIdle();
        compareValue("flagRdEn", flagRdEn, '0);
        compareValue("weiRdEn", weiRdEn, '0);
        compareValue("weiRdy", weiRdy, '0);
        compareValue("flagRdAddr", flagRdAddr, '0);
        compareValue("weiRdAddr", weiRdAddr, '0);
    endtask

    task automatic runFetch();
        weiPkg::flagWordT fw;
        weiPkg::weiBlockT expBlock;
        logic [31:0]      gap;
        int               wordsBefore;
        fw          = flagMem[flagIdx];
        wordsBefore = wordsRead;
        buildExpected(fw, expBlock);
        flagIdx++;
        takeBits(2, gap);
        repeat (gap[1:0]) @(posedge clk);
        @(posedge clk);
        fetch <= 1'b1;
        @(posedge clk);
        fetch <= 1'b0;
        do begin
            @(negedge clk);
        end while (!weiRdy);
        compareValue("weiOut", weiOut, expBlock);
        compareValue("weiFlags", weiFlags, fw);
        // Whole words read so far cover the stream pointer exactly
        compareValue("weiRdAddr", wordsRead, (streamPtr + PortBytes - 1) / PortBytes);
        if (fw == '0) compareValue("weiRdAddr", wordsRead, wordsBefore);
        compareValue("flagRdAddr", flagRdAddr, flagIdx);
    endtask

    task automatic pulseFrameDone();
        @(posedge clk);
        frameDone <= 1'b1;
        @(posedge clk);
        frameDone <= 1'b0;
        @(negedge clk);
        checkIdle();
        streamPtr = 0;
        flagIdx   = 0;
    endtask

    // ==================================================================
    // Read address monitor, sequential with no gap or repeat
    // ==================================================================
    always @(negedge clk) begin
        if (rst_n && frameDone) begin
            expFlagAddr = 0;
            wordsRead   = 0;
        end else if (rst_n) begin
            if (flagRdEn) begin
                compareValue("flagRdAddr", flagRdAddr, expFlagAddr);
                expFlagAddr++;
            end
            if (weiRdEn) begin
                compareValue("weiRdAddr", weiRdAddr, wordsRead);
                wordsRead++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: no weiRdy within %0d cycles", TimeoutCycles);
            $display("Test failures found");
            $fatal(1, "Run stopped on timeout");
        end
    end

    initial begin
        fillMemories();
        repeat (2) @(negedge clk);
        checkIdle();
        wait (rst_n === 1'b1);
        @(negedge clk);
        checkIdle();
        for (int i = 0; i < FetchesA; i++) runFetch();
        // Second frame restarts both buffers at address 0
        pulseFrameDone();
        for (int i = 0; i < FetchesB; i++) runFetch();
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/weiPkg.sv
logic/flagInfoIf.sv
logic/flagFetch.sv
logic/weiGather.sv
logic/weiAlign.sv
logic/weiDistTop.sv
testbench/tbClock.sv
testbench/weiDist_asserts.sv
testbench/weiDistTb.sv

// ==== Makefile ====
# Verilator build and run for the weight distributor

VERILATOR ?= verilator
TOP       ?= weiDistTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
SEED_LOG  ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(SEED_LOG)
	@if grep -q "$(FAIL_MSG)" $(SEED_LOG) || ! grep -q "$(PASS_MSG)" $(SEED_LOG); then \
		echo "Simulation FAILED, see $(SEED_LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)
